//--- flist.f
src/serial_alu_pkg.sv
src/ser_add.sv
src/ser_cmp.sv
src/ser_shift.sv
src/alu_op_regs.sv
src/ser_alu.sv
src/alu_bit_sequencer.sv
src/alu_top.sv
sim/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the serial ALU testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f flist.f \
   --top-module alu_tb \
   -o alu_tb_sim

./obj_dir/alu_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"
exit 0

//--- sim/alu_tb.sv
module alu_tb;
   import serial_alu_pkg::*;

   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        i_rst;
   logic        i_start;
   alu_op_e     i_op;
   cmp_cond_e   i_cond;
   logic [31:0] i_a;
   logic [31:0] i_b;
   logic        o_busy;
   logic        o_done;
   logic [31:0] o_result;
   logic        o_cmp;

   logic [15:0] lfsr = 16'd25567;
   int          errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   alu_top #(
      .XLEN (32)
   ) i_dut (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_start  (i_start),
      .i_op     (i_op),
      .i_cond   (i_cond),
      .i_a      (i_a),
      .i_b      (i_b),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_result (o_result),
      .o_cmp    (o_cmp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   done_clears_busy: assert property (@(posedge clk) disable iff (i_rst) o_done |-> !o_busy)
      else begin
         errors++;
         $display("o_busy was still high while o_done was high");
      end

   done_single_pulse: assert property (@(posedge clk) disable iff (i_rst)
      $past(o_done) |-> !o_done)
      else begin
         errors++;
         $display("o_done stayed high for more than one cycle");
      end

   busy_needs_start: assert property (@(posedge clk) disable iff (i_rst)
      (o_busy && !$past(o_busy)) |-> $past(i_start))
      else begin
         errors++;
         $display("o_busy rose without a start pulse");
      end

   outputs_held: assert property (@(posedge clk) disable iff (i_rst)
      (!o_busy && $past(!o_busy)) |-> ($stable(o_result) && $stable(o_cmp)))
      else begin
         errors++;
         $display("o_result or o_cmp changed while the ALU was idle");
      end

   // 16-bit Fibonacci LFSR with taps 16 14 13 11.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      rand_bits = v;
   endfunction

   function automatic logic [31:0] expect_result(input alu_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
      case (op)
         OP_ADD:  expect_result = a + b;
         OP_SUB:  expect_result = a - b;
         OP_SLT:  expect_result = {31'd0, $signed(a) < $signed(b)};
         OP_SLTU: expect_result = {31'd0, a < b};
         OP_SRL:  expect_result = a >> b[4:0];
         OP_SRA:  expect_result = $signed(a) >>> b[4:0];
         default: expect_result = '0;
      endcase
   endfunction

   function automatic logic expect_cmp(input alu_op_e op, input cmp_cond_e cond,
                                       input logic [31:0] a, input logic [31:0] b);
      logic uns;
      logic lt;
      if ((op == OP_SLT) || (op == OP_SLTU)) begin
         uns = (op == OP_SLTU);   // Op decides signedness for SLT.
      end else begin
         uns = (cond == CC_LTU) || (cond == CC_GEU);
      end
      lt = uns ? (a < b) : ($signed(a) < $signed(b));
      case (cond)
         CC_EQ:        expect_cmp = (a == b);
         CC_NE:        expect_cmp = (a != b);
         CC_LT, CC_LTU: expect_cmp = lt;
         default:      expect_cmp = !lt;
      endcase
   endfunction

   // Returns right after the edge that samples the start pulse.
   task automatic start_op(input alu_op_e op, input cmp_cond_e cond, input logic [31:0] a,
                           input logic [31:0] b);
      @(posedge clk);
      i_start <= 1'b1;
      i_op    <= op;
      i_cond  <= cond;
      i_a     <= a;
      i_b     <= b;
      @(posedge clk);
      i_start <= 1'b0;
   endtask

   task automatic wait_done(output int cycles, output bit ok);
      cycles = 0;
      ok     = 1'b0;
      while (!ok && cycles < 200) begin
         @(negedge clk);
         if (o_done) begin
            ok = 1'b1;
         end else begin
            assert (o_busy) else begin
               errors++;
               $display("mismatch o_busy: got %h expected %h", o_busy, 1'b1);
            end
            cycles++;
         end
      end
      if (!ok) begin
         errors++;
         $display("timeout: o_done did not arrive within 200 cycles");
      end
   endtask

   task automatic run_check(input alu_op_e op, input cmp_cond_e cond, input logic [31:0] a,
                            input logic [31:0] b);
      int          cycles;
      bit          ok;
      logic [31:0] exp_res;
      logic        exp_cmp;
      exp_res = expect_result(op, a, b);
      exp_cmp = expect_cmp(op, cond, a, b);
      start_op(op, cond, a, b);
      wait_done(cycles, ok);
      if (ok) begin
         assert (cycles == 65) else begin
            errors++;
            $display("mismatch o_done delay: got %h expected %h", cycles, 65);
         end
         assert (o_result == exp_res) else begin
            errors++;
            $display("mismatch o_result: got %h expected %h (%s a %h b %h)",
                     o_result, exp_res, op.name(), a, b);
         end
         assert (o_cmp == exp_cmp) else begin
            errors++;
            $display("mismatch o_cmp: got %h expected %h (%s %s a %h b %h)",
                     o_cmp, exp_cmp, op.name(), cond.name(), a, b);
         end
      end
   endtask

   task automatic report_test(input string name, input int base);
      if (errors == base) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail, %0d errors", name, errors - base);
      end
   endtask

   initial begin
      logic [31:0] edge_vals [5];
      logic [31:0] a;
      logic [31:0] b;
      int          base;
      int          cycles;
      bit          ok;
      edge_vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff};
      i_rst   = 1'b1;
      i_start = 1'b0;
      i_op    = OP_ADD;
      i_cond  = CC_EQ;
      i_a     = '0;
      i_b     = '0;
      repeat (3) @(posedge clk);
      i_rst <= 1'b0;

      base = errors;
      @(negedge clk);
      assert (!o_busy && !o_done) else begin
         errors++;
         $display("mismatch o_busy/o_done: got %h/%h expected 0/0", o_busy, o_done);
      end
      assert (o_result == '0 && !o_cmp) else begin
         errors++;
         $display("mismatch o_result/o_cmp: got %h/%h expected 0/0", o_result, o_cmp);
      end
      report_test("reset", base);

      base = errors;
      for (int i = 0; i < 5; i++) begin
         for (int j = 0; j < 5; j++) begin
            run_check(OP_ADD, cmp_cond_e'(3'(rand_bits(3) % 6)), edge_vals[i], edge_vals[j]);
            run_check(OP_SUB, cmp_cond_e'(3'(rand_bits(3) % 6)), edge_vals[i], edge_vals[j]);
         end
      end
      for (int i = 0; i < 20; i++) begin
         run_check(OP_ADD, CC_EQ, rand_bits(32), rand_bits(32));
         run_check(OP_SUB, CC_NE, rand_bits(32), rand_bits(32));
      end
      report_test("arith", base);

      base = errors;
      for (int i = 0; i < 8; i++) begin
         a = rand_bits(32);
         b = a ^ 32'h8000_0000;   // Differs in the sign bit only.
         run_check(OP_SLT, CC_LT, a, b);
         run_check(OP_SLT, CC_GE, b, a);
         run_check(OP_SLTU, CC_LTU, a, b);
         run_check(OP_SLTU, CC_GEU, b, a);
      end
      for (int i = 0; i < 10; i++) begin
         a = rand_bits(32);
         run_check(OP_SLT, CC_EQ, a, a);
         run_check(OP_SLTU, CC_NE, a, rand_bits(32));
         run_check(OP_SLT, CC_LTU, rand_bits(32), rand_bits(32));
      end
      report_test("slt", base);

      base = errors;
      for (int sh = 0; sh < 32; sh++) begin
         a = rand_bits(32);
         b = (rand_bits(32) & 32'hffff_ffe0) | 32'(sh);
         run_check(OP_SRL, CC_EQ, a | 32'h8000_0000, b);
         run_check(OP_SRA, CC_LT, a & 32'h7fff_ffff, b);
         run_check(OP_SRA, CC_GEU, a | 32'h8000_0000, b);
      end
      report_test("shift", base);

      base = errors;
      for (int c = 0; c < 6; c++) begin
         for (int o = 0; o < 6; o++) begin
            a = rand_bits(32);
            run_check(alu_op_e'(3'(o)), cmp_cond_e'(3'(c)), a, rand_bits(32));
            run_check(alu_op_e'(3'(o)), cmp_cond_e'(3'(c)), a, a);
         end
      end
      report_test("branch", base);

      base = errors;
      a = 32'h1234_5678;
      b = 32'h0000_0f0f;
      start_op(OP_ADD, CC_LT, a, b);
      repeat (10) @(posedge clk);
      start_op(OP_SUB, CC_EQ, 32'hdead_beef, 32'h0000_0001);   // Dropped while busy.
      wait_done(cycles, ok);
      if (ok) begin
         assert (cycles == 53) else begin
            errors++;
            $display("mismatch o_done delay: got %h expected %h", cycles + 12, 65);
         end
         assert (o_result == a + b) else begin
            errors++;
            $display("mismatch o_result: got %h expected %h", o_result, a + b);
         end
         assert (o_cmp == expect_cmp(OP_ADD, CC_LT, a, b)) else begin
            errors++;
            $display("mismatch o_cmp: got %h expected %h", o_cmp,
                     expect_cmp(OP_ADD, CC_LT, a, b));
         end
      end
      report_test("timing", base);

      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- src/alu_top.sv
module alu_top
   import serial_alu_pkg::*;
#(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_start,
   input  alu_op_e         i_op,
   input  cmp_cond_e       i_cond,
   input  logic [XLEN-1:0] i_a,
   input  logic [XLEN-1:0] i_b,
   output logic            o_busy,
   output logic            o_done,
   output logic [XLEN-1:0] o_result,
   output logic            o_cmp
);

   logic    init;
   logic    en;
   logic    last_bit;
   logic    rs1;
   logic    op_b;
   logic    rd;
   logic    cmp;
   logic    sub;
   logic    cmp_neg;
   logic    cmp_uns;
   logic    cmp_sel_eq;
   logic    sra;
   rd_sel_e rd_sel;

   alu_bit_sequencer #(
      .XLEN (XLEN)
   ) u_seq (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_start  (i_start),
      .i_a      (i_a),
      .i_b      (i_b),
      .i_rd     (rd),
      .o_init   (init),
      .o_en     (en),
      .o_last   (last_bit),
      .o_rs1    (rs1),
      .o_op_b   (op_b),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_result (o_result)
   );

   alu_op_regs u_op_regs (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_start      (i_start),
      .i_busy       (o_busy),
      .i_op         (i_op),
      .i_cond       (i_cond),
      .i_init       (init),
      .i_last       (last_bit),
      .i_cmp        (cmp),
      .o_sub        (sub),
      .o_cmp_neg    (cmp_neg),
      .o_cmp_uns    (cmp_uns),
      .o_cmp_sel_eq (cmp_sel_eq),
      .o_rd_sel     (rd_sel),
      .o_sra        (sra),
      .o_cmp        (o_cmp)
   );

   ser_alu #(
      .XLEN (XLEN)
   ) u_alu (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_init       (init),
      .i_en         (en),
      .i_last       (last_bit),
      .i_rs1        (rs1),
      .i_op_b       (op_b),
      .i_sub        (sub),
      .i_cmp_neg    (cmp_neg),
      .i_cmp_uns    (cmp_uns),
      .i_cmp_sel_eq (cmp_sel_eq),
      .i_sra        (sra),
      .i_rd_sel     (rd_sel),
      .o_cmp        (cmp),
      .o_rd         (rd)
   );

endmodule

//--- src/alu_bit_sequencer.sv
module alu_bit_sequencer
   import serial_alu_pkg::*;
#(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_start,
   input  logic [XLEN-1:0] i_a,
   input  logic [XLEN-1:0] i_b,
   input  logic            i_rd,
   output logic            o_init,
   output logic            o_en,
   output logic            o_last,
   output logic            o_rs1,
   output logic            o_op_b,
   output logic            o_busy,
   output logic            o_done,
   output logic [XLEN-1:0] o_result
);

   localparam int CW = $clog2(XLEN);

   seq_state_e      state;
   logic            busy_r;
   logic [CW-1:0]   cnt;
   logic            cnt_last;
   logic            accept;
   logic            load;
   logic [XLEN-1:0] a_hold;
   logic [XLEN-1:0] b_hold;
   logic [XLEN-1:0] a_sr;
   logic [XLEN-1:0] b_sr;

   assign accept   = i_start & ~busy_r;
   assign cnt_last = (cnt == CW'(XLEN - 1));

   // Reload at the start of the init pass and again for the run pass.
   assign load = ((state == S_IDLE) && busy_r) || ((state == S_INIT) && cnt_last);

   assign o_init = (state == S_INIT);
   assign o_en   = (state == S_RUN);
   assign o_last = (o_init || o_en) && cnt_last;
   assign o_rs1  = a_sr[0];
   assign o_op_b = b_sr[0];
   assign o_busy = busy_r;
   assign o_done = (state == S_DONE);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state    <= S_IDLE;
         busy_r   <= 1'b0;
         cnt      <= '0;
         o_result <= '0;
      end else begin
         if (accept) begin
            busy_r <= 1'b1;
         end
         case (state)
            S_IDLE: begin
               cnt <= '0;
               if (busy_r) begin
                  state <= S_INIT;
               end
            end
            S_INIT: begin
               cnt <= cnt + 1'b1;   // Wraps to zero for the run pass.
               if (cnt_last) begin
                  state <= S_RUN;
               end
            end
            S_RUN: begin
               cnt      <= cnt + 1'b1;
               o_result <= {i_rd, o_result[XLEN-1:1]};
               if (cnt_last) begin
                  state  <= S_DONE;
                  busy_r <= 1'b0;
               end
            end
            S_DONE: begin
               state <= S_IDLE;
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         a_hold <= i_a;
         b_hold <= i_b;
      end
      if (load) begin
         a_sr <= a_hold;
         b_sr <= b_hold;
      end else begin
         a_sr <= a_sr >> 1;
         b_sr <= b_sr >> 1;
      end
   end

endmodule

//--- src/ser_alu.sv
module ser_alu
   import serial_alu_pkg::*;
#(
   parameter int XLEN = 32
) (
   input  logic    clk,
   input  logic    i_rst,
   input  logic    i_init,
   input  logic    i_en,
   input  logic    i_last,
   input  logic    i_rs1,
   input  logic    i_op_b,
   input  logic    i_sub,
   input  logic    i_cmp_neg,
   input  logic    i_cmp_uns,
   input  logic    i_cmp_sel_eq,
   input  logic    i_sra,
   input  rd_sel_e i_rd_sel,
   output logic    o_cmp,
   output logic    o_rd
);

   logic en_r;
   logic init_r;
   logic plus_1;
   logic init_first;
   logic b_neg;
   logic add_b;
   logic result_add;
   logic result_eq;
   logic result_lt;
   logic result_sh;
   logic slt_r;

   assign plus_1     = i_en & ~en_r;       // First bit of the run pass.
   assign init_first = i_init & ~init_r;

   ser_add u_neg_b (
      .clk   (clk),
      .i_clr (~i_en),
      .i_a   (~i_op_b),
      .i_b   (plus_1),
      .o_q   (b_neg)
   );

   assign add_b = i_sub ? b_neg : i_op_b;

   ser_add u_add (
      .clk   (clk),
      .i_clr (~i_en),
      .i_a   (i_rs1),
      .i_b   (add_b),
      .o_q   (result_add)
   );

   ser_cmp u_cmp (
      .clk    (clk),
      .i_clr  (~i_init),
      .i_last (i_last),
      .i_uns  (i_cmp_uns),
      .i_a    (i_rs1),
      .i_b    (i_op_b),
      .o_eq   (result_eq),
      .o_lt   (result_lt)
   );

   ser_shift #(
      .XLEN (XLEN)
   ) u_shift (
      .clk         (clk),
      .i_init      (i_init),
      .i_en        (i_en),
      .i_first     (init_first),
      .i_d         (i_rs1),
      .i_shamt_bit (i_op_b),
      .i_sra       (i_sra),
      .o_q         (result_sh)
   );

   assign o_cmp = i_cmp_neg ^ (i_cmp_sel_eq ? result_eq : result_lt);

   always_comb begin
      case (i_rd_sel)
         RD_ADD:   o_rd = result_add;
         RD_SHIFT: o_rd = result_sh;
         RD_LT:    o_rd = slt_r & plus_1;   // Only bit 0 can be set.
         default:  o_rd = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         en_r   <= 1'b0;
         init_r <= 1'b0;
      end else begin
         en_r   <= i_en;
         init_r <= i_init;
      end
   end

   always_ff @(posedge clk) begin
      if (i_init && i_last) begin
         slt_r <= result_lt;
      end
   end

endmodule

//--- src/alu_op_regs.sv
module alu_op_regs
   import serial_alu_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_start,
   input  logic      i_busy,
   input  alu_op_e   i_op,
   input  cmp_cond_e i_cond,
   input  logic      i_init,
   input  logic      i_last,
   input  logic      i_cmp,
   output logic      o_sub,
   output logic      o_cmp_neg,
   output logic      o_cmp_uns,
   output logic      o_cmp_sel_eq,
   output rd_sel_e   o_rd_sel,
   output logic      o_sra,
   output logic      o_cmp
);

   alu_op_e   op_r;
   cmp_cond_e cond_r;
   logic      is_slt;
   logic      cond_uns;

   assign is_slt   = (op_r == OP_SLT) || (op_r == OP_SLTU);
   assign cond_uns = (cond_r == CC_LTU) || (cond_r == CC_GEU);

   assign o_sub        = (op_r == OP_SUB) || is_slt;
   assign o_cmp_neg    = (cond_r == CC_NE) || (cond_r == CC_GE) || (cond_r == CC_GEU);
   assign o_cmp_sel_eq = (cond_r == CC_EQ) || (cond_r == CC_NE);
   assign o_cmp_uns    = is_slt ? (op_r == OP_SLTU) : cond_uns;   // Op decides for SLT.
   assign o_sra        = (op_r == OP_SRA);

   always_comb begin
      case (op_r)
         OP_SRL, OP_SRA:  o_rd_sel = RD_SHIFT;
         OP_SLT, OP_SLTU: o_rd_sel = RD_LT;
         default:         o_rd_sel = RD_ADD;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         op_r   <= OP_ADD;
         cond_r <= CC_EQ;
         o_cmp  <= 1'b0;
      end else begin
         if (i_start && !i_busy) begin
            op_r   <= i_op;
            cond_r <= i_cond;
         end
         if (i_init && i_last) begin
            o_cmp <= i_cmp;   // Branch result is final on the MSB.
         end
      end
   end

endmodule

//--- src/ser_shift.sv
module ser_shift
   import serial_alu_pkg::*;
#(
   parameter int XLEN = 32
) (
   input  logic clk,
   input  logic i_init,
   input  logic i_en,
   input  logic i_first,
   input  logic i_d,
   input  logic i_shamt_bit,
   input  logic i_sra,
   output logic o_q
);

   localparam int CW = $clog2(XLEN);
   localparam int SW = ((CW > 5) ? CW : 5) + 1;

   logic [XLEN-1:0] data_r;
   shamt_t          shamt_r;
   logic [CW-1:0]   idx_r;
   logic [CW-1:0]   cur_idx;
   logic [SW-1:0]   src_idx;
   logic            src_bit;

   // Index of the bit on the serial lines this cycle.
   assign cur_idx = i_first ? '0 : idx_r;

   assign src_idx = SW'(cur_idx) + SW'(shamt_r);

   always_comb begin
      if (src_idx >= SW'(XLEN)) begin
         src_bit = i_sra & data_r[XLEN-1];   // Fill past the top.
      end else begin
         src_bit = data_r[src_idx[CW-1:0]];
      end
   end

   assign o_q = i_en & src_bit;

   // Counter wraps at the pass boundary, so run indices restart at 0.
   always_ff @(posedge clk) begin
      if (i_first) begin
         idx_r <= CW'(1);
      end else begin
         idx_r <= idx_r + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_init) begin
         data_r <= {i_d, data_r[XLEN-1:1]};   // Fills in bit order.
         if (cur_idx < CW'(5)) begin
            shamt_r[cur_idx[2:0]] <= i_shamt_bit;
         end
      end
   end

endmodule

//--- src/ser_cmp.sv
module ser_cmp (
   input  logic clk,
   input  logic i_clr,
   input  logic i_last,
   input  logic i_uns,
   input  logic i_a,
   input  logic i_b,
   output logic o_eq,
   output logic o_lt
);

   logic eq_r;
   logic lt_r;
   logic bit_diff;
   logic bit_lt;
   logic msb_lt;

   assign bit_diff = i_a ^ i_b;
   assign bit_lt   = ~i_a & i_b;   // Unsigned order of the current bit.

   // On the sign bit a set a means negative in signed order.
   assign msb_lt = i_uns ? bit_lt : (i_a & ~i_b);

   assign o_eq = eq_r & ~bit_diff;

   always_comb begin
      if (!bit_diff) begin
         o_lt = lt_r;   // Equal bits defer to the lower bits.
      end else if (i_last) begin
         o_lt = msb_lt;
      end else begin
         o_lt = bit_lt;
      end
   end

   // Bits arrive LSB first, so a later differing bit overrides.
   always_ff @(posedge clk) begin
      if (i_clr) begin
         eq_r <= 1'b1;
         lt_r <= 1'b0;
      end else begin
         eq_r <= o_eq;
         if (bit_diff) begin
            lt_r <= bit_lt;
         end
      end
   end

endmodule

//--- src/ser_add.sv
module ser_add (
   input  logic clk,
   input  logic i_clr,
   input  logic i_a,
   input  logic i_b,
   output logic o_q
);

   logic carry_r;
   logic carry_nxt;

   assign o_q       = i_a ^ i_b ^ carry_r;
   assign carry_nxt = (i_a & i_b) | (i_a & carry_r) | (i_b & carry_r);

   // Clear holds the carry at zero so the next pass starts from bit 0.
   always_ff @(posedge clk) begin
      if (i_clr) begin
         carry_r <= 1'b0;
      end else begin
         carry_r <= carry_nxt;
      end
   end

endmodule

//--- src/serial_alu_pkg.sv
package serial_alu_pkg;

   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_SLT  = 3'd2,
      OP_SLTU = 3'd3,
      OP_SRL  = 3'd4,
      OP_SRA  = 3'd5
   } alu_op_e;

   typedef enum logic [2:0] {
      CC_EQ  = 3'd0,
      CC_NE  = 3'd1,
      CC_LT  = 3'd2,
      CC_GE  = 3'd3,
      CC_LTU = 3'd4,
      CC_GEU = 3'd5
   } cmp_cond_e;

   typedef enum logic [1:0] {
      RD_ADD   = 2'd0,
      RD_SHIFT = 2'd1,
      RD_LT    = 2'd2
   } rd_sel_e;

   typedef logic [4:0] shamt_t;   // Right shift amount.

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,
      S_INIT = 2'd1,
      S_RUN  = 2'd2,
      S_DONE = 2'd3
   } seq_state_e;

endpackage
